//--- Makefile
# Verilator build for the command sequencer testbench
VERILATOR ?= verilator
TOP ?= tb_sched
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_MSG ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_sched.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module tb_sched;

	localparam int DIV = `SCHED_TICK_DIV;
	localparam int DEPTH = `SCHED_FIFO_DEPTH;
	localparam int CHANS = `SCHED_CHAN_COUNT;
	localparam int DW = `SCHED_DATA_W;

	logic clk;
	logic rst;
	logic start;
	logic cmd_wr_en;
	logic [`SCHED_CMD_W-1:0] cmd_wr_data;
	logic cmd_full;
	logic [`SCHED_TIME_W-1:0] current_time;
	logic [`SCHED_ADDR_W-1:0] bus_addr;
	logic [`SCHED_DATA_W-1:0] bus_data;
	logic bus_wr;
	logic [CHANS*DW-1:0] chan_words;

	// bus writes seen so far with current_time at the strobe in when
	sched_pkg::sched_cmd_t wr_log [$];
	int unsigned wr_cycle [$];
	sched_pkg::sched_cmd_t mon_rec;
	int unsigned neg_count;
	// watchdog limit in clock cycles that grows with every reset and queued command
	longint unsigned budget = 200;
	longint unsigned cycles_run = 0;
	integer seed;

	sched_top sched_top_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.cmd_wr_en(cmd_wr_en),
		.cmd_wr_data(cmd_wr_data),
		.cmd_full(cmd_full),
		.current_time(current_time),
		.bus_addr(bus_addr),
		.bus_data(bus_data),
		.bus_wr(bus_wr),
		.chan_words(chan_words)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// bus monitor samples at the falling edge where outputs are settled
	always @(negedge clk) begin
		neg_count++;
		if (!rst && bus_wr) begin
			mon_rec.when = current_time;
			mon_rec.data = bus_data;
			mon_rec.addr = bus_addr;
			wr_log.push_back(mon_rec);
			wr_cycle.push_back(neg_count);
		end
	end

	initial begin
		while (cycles_run <= budget) begin
			@(posedge clk);
			cycles_run++;
		end
		$display("timeout: the run hung after %0d clock cycles", cycles_run);
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			$display("** FAIL **");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_addr(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			$display("** FAIL **");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_cmd(input string name, input sched_pkg::sched_cmd_t exp,
			input sched_pkg::sched_cmd_t act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h/%h/%h actual %h/%h/%h", name,
				exp.when, exp.data, exp.addr, act.when, act.data, act.addr);
			$display("** FAIL **");
			$fatal(1, "command mismatch");
		end
	endtask

	task automatic report_error(input string msg);
		$display("error: %s", msg);
		$display("** FAIL **");
		$fatal(1, "check failed");
	endtask

	function automatic sched_pkg::sched_cmd_t make_cmd(input logic [31:0] t,
			input logic [31:0] d, input logic [15:0] a);
		sched_pkg::sched_cmd_t c;
		c.when = t;
		c.data = d;
		c.addr = a;
		return c;
	endfunction

	// pin-control address of 12 base bits over a 4 bit channel index
	function automatic logic [15:0] chan_addr(input logic [11:0] base, input int idx);
		return {base, 4'(idx)};
	endfunction

	function automatic logic [31:0] chan_word(input int idx);
		return chan_words[idx*DW +: DW];
	endfunction

	// two cycle reset that also restarts time at 0
	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		start <= 1'b0;
		cmd_wr_en <= 1'b0;
		repeat (2) @(posedge clk);
		wr_log.delete();
		wr_cycle.delete();
		budget += 100;
		rst <= 1'b0;
	endtask

	task automatic start_time_base();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic push_cmd(input sched_pkg::sched_cmd_t c);
		budget += c.when * DIV + 40;
		@(posedge clk);
		cmd_wr_en <= 1'b1;
		cmd_wr_data <= c;
		@(posedge clk);
		cmd_wr_en <= 1'b0;
	endtask

	task automatic wait_writes(input int n);
		while (wr_log.size() < n)
			@(posedge clk);
	endtask

	task automatic wait_time(input logic [31:0] t);
		while (current_time < t)
			@(negedge clk);
	endtask

	task automatic reset_state();
		int i;
		apply_reset();
		for (i = 0; i < 2; i++)
			push_cmd(make_cmd(32'd1, $random(seed), chan_addr(`SCHED_PIN_BASE, i)));
		// never started, so time and bus stay quiet
		repeat (10 * DIV) begin
			@(negedge clk);
			check_word("reset_state time", '0, current_time);
		end
		if (wr_log.size() != 0)
			report_error("reset_state: bus write seen before the time base was started");
		for (i = 0; i < CHANS; i++)
			check_word("reset_state channel", '0, chan_word(i));
	endtask

	task automatic time_advance();
		int n;
		int c;
		apply_reset();
		start_time_base();
		n = 0;
		// counting begins the cycle after start and the first tick comes DIV cycles later
		do begin
			@(negedge clk);
			n++;
		end while (current_time == '0 && n < 4 * DIV);
		check_word("time_advance first tick", 32'(DIV + 1), 32'(n));
		for (c = 1; c <= 8 * DIV; c++) begin
			@(negedge clk);
			check_word("time_advance count", 32'(1 + c / DIV), current_time);
		end
	endtask

	task automatic timed_dispatch();
		sched_pkg::sched_cmd_t exp [3];
		int i;
		apply_reset();
		for (i = 0; i < 3; i++) begin
			exp[i] = make_cmd(32'(10 * (i + 1)), $random(seed), chan_addr(`SCHED_PIN_BASE, i));
			push_cmd(exp[i]);
		end
		start_time_base();
		wait_writes(3);
		@(negedge clk);
		// a held command strobes in the first cycle its time is reached
		for (i = 0; i < 3; i++) begin
			check_cmd("timed_dispatch", exp[i], wr_log[i]);
			check_word("timed_dispatch channel", exp[i].data, chan_word(i));
		end
	endtask

	task automatic in_order_and_late();
		sched_pkg::sched_cmd_t exp [4];
		int unsigned late_when [4];
		int unsigned gap;
		int i;
		late_when = '{12, 3, 7, 1};
		apply_reset();
		start_time_base();
		wait_time(32'd12);
		for (i = 0; i < 4; i++) begin
			exp[i] = make_cmd(late_when[i], $random(seed), chan_addr(`SCHED_PIN_BASE, i));
			push_cmd(exp[i]);
		end
		wait_writes(4);
		for (i = 0; i < 4; i++) begin
			check_addr("in_order_and_late addr", exp[i].addr, wr_log[i].addr);
			check_word("in_order_and_late data", exp[i].data, wr_log[i].data);
			if (i > 0) begin
				// cycles from one strobe to the next with both strobe cycles counted
				gap = wr_cycle[i] - wr_cycle[i-1] + 1;
				if (gap < 5)
					report_error("in_order_and_late: bus writes closer than 5 cycles");
				// due commands with the queue kept busy go out at the minimum spacing
				else if (gap > 5)
					report_error("in_order_and_late: a late command was held back");
			end
		end
	endtask

	task automatic address_decode();
		logic [31:0] model [CHANS];
		logic [15:0] bad_addr [4];
		int i;
		apply_reset();
		start_time_base();
		for (i = 0; i < CHANS; i++) begin
			model[i] = $random(seed);
			push_cmd(make_cmd(32'd1, model[i], chan_addr(`SCHED_PIN_BASE, i)));
		end
		// wrong base, or an index past the last channel
		bad_addr[0] = chan_addr(12'h0A1, 0);
		bad_addr[1] = chan_addr(12'h000, 1);
		bad_addr[2] = chan_addr(`SCHED_PIN_BASE, CHANS);
		bad_addr[3] = chan_addr(`SCHED_PIN_BASE, 15);
		for (i = 0; i < 4; i++)
			push_cmd(make_cmd(32'd1, $random(seed), bad_addr[i]));
		wait_writes(CHANS);
		@(negedge clk);
		for (i = 0; i < CHANS; i++)
			check_word("address_decode valid", model[i], chan_word(i));
		wait_writes(CHANS + 4);
		@(negedge clk);
		for (i = 0; i < CHANS; i++)
			check_word("address_decode ignored", model[i], chan_word(i));
	endtask

	task automatic queue_full();
		sched_pkg::sched_cmd_t exp [DEPTH+1];
		int i;
		apply_reset();
		// commands 2 time units apart leave room for the write spacing
		for (i = 0; i <= DEPTH; i++) begin
			exp[i] = make_cmd(32'(40 + 2 * i), $random(seed),
				chan_addr(`SCHED_PIN_BASE, i % CHANS));
			push_cmd(exp[i]);
			@(negedge clk);
			check_word("queue_full flag", 32'(i + 1 >= DEPTH), 32'(cmd_full));
		end
		start_time_base();
		wait_writes(DEPTH);
		// the dropped command would have gone out at 40 + 2*DEPTH
		wait_time(32'(44 + 2 * DEPTH));
		check_word("queue_full write count", 32'(DEPTH), 32'(wr_log.size()));
		for (i = 0; i < DEPTH; i++)
			check_cmd("queue_full dispatch", exp[i], wr_log[i]);
	endtask

	initial begin
		seed = 32'h820aa865;
		neg_count = 0;
		rst = 1'b1;
		start = 1'b0;
		cmd_wr_en = 1'b0;
		cmd_wr_data = '0;
		reset_state();
		time_advance();
		timed_dispatch();
		in_order_and_late();
		address_decode();
		queue_full();
		$display("** PASS **");
		$finish;
	end

endmodule

//--- files.f
+incdir+include
rtl/sched_pkg.sv
rtl/cmd_bus_if.sv
rtl/time_base.sv
rtl/cmd_fifo.sv
rtl/scheduler.sv
rtl/pin_control.sv
rtl/sched_top.sv
bench/tb_sched.sv

//--- include/sched_defines.svh
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// widths of the command fields
`define SCHED_TIME_W 32
`define SCHED_DATA_W 32
`define SCHED_ADDR_W 16
`define SCHED_CMD_W 80

// command layout, time on top and address at the bottom
`define SCHED_TIME_H 79
`define SCHED_TIME_L 48
`define SCHED_DATA_H 47
`define SCHED_DATA_L 16
`define SCHED_ADDR_H 15
`define SCHED_ADDR_L 0

// queue entries, must be a power of two
`define SCHED_FIFO_DEPTH 8
// clock cycles per time unit
`define SCHED_TICK_DIV 4
// pin-control channels and their upper address bits
`define SCHED_CHAN_COUNT 4
`define SCHED_PIN_BASE 12'h0A0

`endif

//--- rtl/cmd_bus_if.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

// internal write-only command bus
interface cmd_bus_if;
	// address and data hold from one command latch to the next
	logic [`SCHED_ADDR_W-1:0] addr;
	logic [`SCHED_DATA_W-1:0] data;
	// single cycle strobe, en and wr high together
	logic en;
	logic wr;

	// master side
	modport scheduler (output addr, output data, output en, output wr);

	// register banks on the bus
	modport channel (input addr, input data, input en, input wr);

endinterface

//--- rtl/cmd_fifo.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module cmd_fifo (
	input  logic clk,
	input  logic rst,
	input  logic wr_en,
	input  sched_pkg::sched_cmd_t wr_data,
	output logic full,
	input  logic rd_en,
	output sched_pkg::sched_cmd_t dout,
	output logic valid,
	output logic empty
);

	localparam int DEPTH = `SCHED_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	sched_pkg::sched_cmd_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic push;
	logic pop;

	// full and empty are registered, so they gate the request directly
	assign push = wr_en && !full;
	assign pop = rd_en && !empty;

	// occupancy after this cycle
	always_comb begin
		count_next = count;
		if (push && !pop)
			count_next = count + 1'b1;
		else if (pop && !push)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
			valid <= 1'b0;
		end else begin
			// pointers wrap at the last entry
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count_next;
			full <= (count_next == CNT_W'(DEPTH));
			empty <= (count_next == '0);
			// dout is good exactly one cycle after the pop
			valid <= pop;
		end
	end

	// storage and registered read port
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_data;
		if (pop)
			dout <= mem[rd_ptr];
	end

endmodule

//--- rtl/pin_control.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module pin_control (
	input  logic clk,
	input  logic rst,
	// write side of the command bus
	cmd_bus_if.channel bus,
	// one data word per channel
	output logic [`SCHED_DATA_W-1:0] chan_words [`SCHED_CHAN_COUNT]
);

	// low nibble selects the channel, the rest selects this block
	localparam int IDX_W = 4;
	localparam int BASE_W = `SCHED_ADDR_W - IDX_W;

	logic [BASE_W-1:0] base_sel;
	logic [IDX_W-1:0] chan_sel;
	logic base_hit;
	logic chan_ok;
	logic wr_hit;

	assign base_sel = bus.addr[`SCHED_ADDR_W-1:IDX_W];
	assign chan_sel = bus.addr[IDX_W-1:0];

	// base must match exactly
	assign base_hit = (base_sel == BASE_W'(`SCHED_PIN_BASE));
	// indices past the last channel are ignored
	assign chan_ok = (int'(chan_sel) < `SCHED_CHAN_COUNT);

	// write strobe aimed at one of our channels
	assign wr_hit = bus.en && bus.wr && base_hit && chan_ok;

	// one register per channel
	for (genvar g = 0; g < `SCHED_CHAN_COUNT; g++) begin : g_chan
		logic sel;

		assign sel = wr_hit && (chan_sel == IDX_W'(g));

		// updates at the edge that ends the strobe cycle
		always_ff @(posedge clk or posedge rst) begin
			if (rst)
				chan_words[g] <= '0;
			else if (sel)
				chan_words[g] <= bus.data;
		end
	end

endmodule

//--- rtl/sched_pkg.sv
`include "sched_defines.svh"

package sched_pkg;

	// scheduler control states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_FIFO_WAIT,
		ST_EXEC,
		ST_EXEC_WAIT
	} sched_state_e;

	// one timed command as it sits in the queue
	// field order gives time in the top bits and address in the bottom bits
	typedef struct packed {
		// execution time
		logic [`SCHED_TIME_W-1:0] when;
		// word written on the bus
		logic [`SCHED_DATA_W-1:0] data;
		// target bus address
		logic [`SCHED_ADDR_W-1:0] addr;
	} sched_cmd_t;

endpackage

//--- rtl/sched_top.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module sched_top (
	input  logic clk,
	input  logic rst,
	// starts the time base
	input  logic start,
	// host push into the command queue
	input  logic cmd_wr_en,
	input  logic [`SCHED_CMD_W-1:0] cmd_wr_data,
	output logic cmd_full,
	// observation
	output logic [`SCHED_TIME_W-1:0] current_time,
	output logic [`SCHED_ADDR_W-1:0] bus_addr,
	output logic [`SCHED_DATA_W-1:0] bus_data,
	output logic bus_wr,
	output logic [`SCHED_CHAN_COUNT*`SCHED_DATA_W-1:0] chan_words
);

	sched_pkg::sched_cmd_t wr_cmd;
	sched_pkg::sched_cmd_t cmd_dout;
	logic cmd_rd_en;
	logic cmd_valid;
	logic cmd_empty;
	logic [`SCHED_DATA_W-1:0] chan_arr [`SCHED_CHAN_COUNT];

	cmd_bus_if bus ();

	// split the flat host word into its fields
	assign wr_cmd.when = cmd_wr_data[`SCHED_TIME_H:`SCHED_TIME_L];
	assign wr_cmd.data = cmd_wr_data[`SCHED_DATA_H:`SCHED_DATA_L];
	assign wr_cmd.addr = cmd_wr_data[`SCHED_ADDR_H:`SCHED_ADDR_L];

	time_base time_base_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.current_time(current_time)
	);

	cmd_fifo cmd_fifo_inst (
		.clk(clk),
		.rst(rst),
		.wr_en(cmd_wr_en),
		.wr_data(wr_cmd),
		.full(cmd_full),
		.rd_en(cmd_rd_en),
		.dout(cmd_dout),
		.valid(cmd_valid),
		.empty(cmd_empty)
	);

	scheduler scheduler_inst (
		.clk(clk),
		.rst(rst),
		.current_time(current_time),
		.cmd_dout(cmd_dout),
		.cmd_empty(cmd_empty),
		.cmd_valid(cmd_valid),
		.cmd_rd_en(cmd_rd_en),
		.bus(bus.scheduler)
	);

	pin_control pin_control_inst (
		.clk(clk),
		.rst(rst),
		.bus(bus.channel),
		.chan_words(chan_arr)
	);

	// bus observation
	assign bus_addr = bus.addr;
	assign bus_data = bus.data;
	assign bus_wr = bus.wr;

	// channel 0 in the low word
	for (genvar g = 0; g < `SCHED_CHAN_COUNT; g++) begin : g_flat
		assign chan_words[g*`SCHED_DATA_W +: `SCHED_DATA_W] = chan_arr[g];
	end

endmodule

//--- rtl/scheduler.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module scheduler (
	input  logic clk,
	input  logic rst,
	// running time from the time base
	input  logic [`SCHED_TIME_W-1:0] current_time,
	// command queue side
	input  sched_pkg::sched_cmd_t cmd_dout,
	input  logic cmd_empty,
	input  logic cmd_valid,
	output logic cmd_rd_en,
	// internal command bus
	cmd_bus_if.scheduler bus
);

	sched_pkg::sched_state_e state;
	sched_pkg::sched_state_e state_next;

	// command being held until its time
	sched_pkg::sched_cmd_t cmd_q;
	logic load_cmd;
	logic time_zero;
	logic cmd_due;

	assign time_zero = (current_time == '0);
	// late commands count as due
	assign cmd_due = (current_time >= cmd_q.when);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= sched_pkg::ST_IDLE;
		else
			state <= state_next;
	end

	// next state and strobes, outputs are not registered
	always_comb begin
		state_next = state;
		cmd_rd_en = 1'b0;
		load_cmd = 1'b0;
		bus.en = 1'b0;
		bus.wr = 1'b0;
		case (state)
			sched_pkg::ST_IDLE: begin
				// stay put until the time base has started
				if (!time_zero)
					state_next = sched_pkg::ST_FETCH;
			end
			sched_pkg::ST_FETCH: begin
				// one read pulse, only when something is queued
				if (!cmd_empty && !time_zero) begin
					cmd_rd_en = 1'b1;
					state_next = sched_pkg::ST_FIFO_WAIT;
				end
			end
			sched_pkg::ST_FIFO_WAIT: begin
				// take the command at this edge
				if (cmd_valid) begin
					load_cmd = 1'b1;
					state_next = sched_pkg::ST_EXEC;
				end
			end
			sched_pkg::ST_EXEC: begin
				// hold until the command time is reached or passed
				if (cmd_due) begin
					bus.en = 1'b1;
					bus.wr = 1'b1;
					state_next = sched_pkg::ST_EXEC_WAIT;
				end
			end
			sched_pkg::ST_EXEC_WAIT: begin
				// settle cycle for the channel registers
				// addr and data stay stable, no strobe here
				state_next = sched_pkg::ST_FETCH;
			end
			default: begin
				state_next = sched_pkg::ST_IDLE;
			end
		endcase
	end

	// command register
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			cmd_q <= '0;
		else if (load_cmd)
			cmd_q <= cmd_dout;
	end

	// address and data straight from the held command
	assign bus.addr = cmd_q.addr;
	assign bus.data = cmd_q.data;

endmodule

//--- rtl/time_base.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module time_base (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic [`SCHED_TIME_W-1:0] current_time
);

	// prescaler needs at least one bit even for a divider of 1
	localparam int DIV = `SCHED_TICK_DIV;
	localparam int PRE_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic running;
	logic [PRE_W-1:0] prescale;
	logic tick;

	// last prescale cycle of a time unit
	assign tick = (prescale == PRE_W'(DIV - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			running <= 1'b0;
			prescale <= '0;
			current_time <= '0;
		end else if (!running) begin
			// sticky start, counting begins on the following cycle
			running <= start;
		end else if (tick) begin
			prescale <= '0;
			current_time <= current_time + 1'b1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule
